/* b32p_lite.f */
+incdir+logic
logic/isa_pkg.sv
logic/pipe_pkg.sv
logic/hazard_control.sv
logic/fetch_unit.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/branch_stage.sv
logic/cpu_top.sv
sim/cpu_tb.sv

/* logic/branch_stage.sv */
//////////////////////////////////////////////////
// memory stage
// branch compare, redirect target and the
// write-back register behind the output port
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "cpu_config.svh"

module branch_stage
(
    input  logic                   clk,
    input  logic                   reset,
    input  pipe_pkg::hazard_ctrl_t ctrl,
    input  pipe_pkg::ex_mem_t      ex_mem,
    input  logic                   wb_ready,
    output logic                   redirect,
    output logic [`XLEN-1:0]       redirect_target,
    output logic                   wb_valid,
    output pipe_pkg::wb_t          wb_data
);

    logic eq;
    logic lt;
    logic taken;

    assign eq = ex_mem.a_val == ex_mem.b_val;
    assign lt = ex_mem.dec.sig ? ($signed(ex_mem.a_val) < $signed(ex_mem.b_val))
                               : (ex_mem.a_val < ex_mem.b_val);

    always_comb
    begin
        case (ex_mem.dec.branch_op)
            isa_pkg::BR_EQ: taken = eq;
            isa_pkg::BR_GT: taken = !lt && !eq;
            isa_pkg::BR_GE: taken = !lt;
            isa_pkg::BR_NE: taken = !eq;
            isa_pkg::BR_LT: taken = lt;
            isa_pkg::BR_LE: taken = lt || eq;
            default:        taken = 1'b0;   // codes 3 and 7
        endcase
    end

    always_comb
    begin
        redirect        = 1'b0;
        redirect_target = ex_mem.pc;    // halt jumps to itself
        case (ex_mem.dec.opcode)
            isa_pkg::OP_BRANCH:
            begin
                redirect        = taken;
                redirect_target = ex_mem.pc +
                    {{(`XLEN-`BR_OFF_BITS){ex_mem.dec.br_off[`BR_OFF_BITS-1]}}, ex_mem.dec.br_off};
            end
            isa_pkg::OP_JUMP:
            begin
                redirect        = 1'b1;
                redirect_target = {{(`XLEN-`JUMP_BITS){1'b0}}, ex_mem.dec.jump_target};
            end
            isa_pkg::OP_HALT: redirect = 1'b1;
            default:          redirect = 1'b0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            wb_valid <= 1'b0;
        else if (!ctrl.hold_all)
            wb_valid <= ex_mem.dec.reg_write;
    end

    always_ff @(posedge clk)
    begin
        if (!ctrl.hold_all)
        begin
            wb_data.dreg  <= ex_mem.dec.dreg;
            wb_data.value <= ex_mem.result;
        end
    end

    // record waits unchanged until the port takes it
    a_wb_stable: assert property (@(posedge clk) disable iff (reset)
        wb_valid && !wb_ready |=> wb_valid && $stable(wb_data));

endmodule

/* logic/cpu_config.svh */
//////////////////////////////////////////////////
// core widths, register count and reset address
// bit positions of the instruction fields
//////////////////////////////////////////////////
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

`define XLEN        32          // data and pc width
`define REG_COUNT   16
`define REG_BITS    4
`define PC_START    32'h0       // first fetch after reset
`define CONST_BITS  16
`define BR_OFF_BITS 12
`define JUMP_BITS   27

// low bit of each instruction field
`define OPC_LSB     28
`define ALUOP_LSB   24
`define DREG_LSB    20
`define AREG_LSB    16
`define BREG_LSB    12
`define BRCOND_LSB  25
`define SIGN_BIT    24

`endif

/* logic/cpu_top.sv */
//////////////////////////////////////////////////
// five stage pipeline top level
// stage instances and hazard control wiring
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpu_top
(
    input  logic              clk,
    input  logic              reset,
    output logic [`XLEN-1:0]  fetch_addr,
    input  logic [`XLEN-1:0]  fetch_instr,
    output logic              wb_valid,
    input  logic              wb_ready,
    output pipe_pkg::wb_t     wb_data
);

    pipe_pkg::fe_de_t       fe_de;
    pipe_pkg::de_ex_t       de_ex;
    pipe_pkg::ex_mem_t      ex_mem;
    pipe_pkg::hazard_ctrl_t ctrl;
    logic                   redirect;
    logic [`XLEN-1:0]       redirect_target;

    fetch_unit u_fetch (
        .clk             (clk),
        .reset           (reset),
        .ctrl            (ctrl),
        .redirect        (redirect),
        .redirect_target (redirect_target),
        .fetch_instr     (fetch_instr),
        .fetch_addr      (fetch_addr),
        .fe_de           (fe_de)
    );

    decode_stage u_decode (
        .clk      (clk),
        .reset    (reset),
        .ctrl     (ctrl),
        .fe_de    (fe_de),
        .wb_valid (wb_valid),
        .wb_ready (wb_ready),
        .wb_data  (wb_data),
        .de_ex    (de_ex)
    );

    execute_stage u_execute (
        .clk        (clk),
        .reset      (reset),
        .ctrl       (ctrl),
        .de_ex      (de_ex),
        .mem_result (ex_mem.result),    // mem stage forwarding source
        .wb_data    (wb_data),
        .ex_mem     (ex_mem)
    );

    branch_stage u_branch (
        .clk             (clk),
        .reset           (reset),
        .ctrl            (ctrl),
        .ex_mem          (ex_mem),
        .wb_ready        (wb_ready),
        .redirect        (redirect),
        .redirect_target (redirect_target),
        .wb_valid        (wb_valid),
        .wb_data         (wb_data)
    );

    hazard_control u_hazard (
        .redirect    (redirect),
        .wb_valid    (wb_valid),
        .wb_ready    (wb_ready),
        .ex_areg     (de_ex.dec.areg),
        .ex_breg     (de_ex.dec.breg),
        .mem_dreg    (ex_mem.dec.dreg),
        .mem_dreg_we (ex_mem.dec.reg_write),
        .wb_dreg     (wb_data.dreg),
        .ctrl        (ctrl)
    );

endmodule

/* logic/decode_stage.sv */
//////////////////////////////////////////////////
// decode stage
// field split, register bank with write bypass,
// decode/execute latch
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "cpu_config.svh"

module decode_stage
(
    input  logic                   clk,
    input  logic                   reset,
    input  pipe_pkg::hazard_ctrl_t ctrl,
    input  pipe_pkg::fe_de_t       fe_de,
    input  logic                   wb_valid,
    input  logic                   wb_ready,
    input  pipe_pkg::wb_t          wb_data,
    output pipe_pkg::de_ex_t       de_ex
);

    isa_pkg::decoded_t      dec;
    logic [`CONST_BITS-1:0] const_raw;
    logic [`XLEN-1:0]       regs [`REG_COUNT];
    logic [`XLEN-1:0]       a_val;
    logic [`XLEN-1:0]       b_val;
    logic                   wb_fire;

    assign wb_fire   = wb_valid && wb_ready;
    assign const_raw = fe_de.instr[`CONST_BITS-1:0];

    always_comb
    begin
        dec.opcode      = isa_pkg::opcode_e'(fe_de.instr[`OPC_LSB +: 4]);
        dec.alu_op      = isa_pkg::alu_op_e'(fe_de.instr[`ALUOP_LSB +: 4]);
        dec.branch_op   = isa_pkg::branch_op_e'(fe_de.instr[`BRCOND_LSB +: 3]);
        dec.sig         = fe_de.instr[`SIGN_BIT];
        dec.dreg        = fe_de.instr[`DREG_LSB +: `REG_BITS];
        dec.areg        = fe_de.instr[`AREG_LSB +: `REG_BITS];
        dec.breg        = fe_de.instr[`BREG_LSB +: `REG_BITS];
        dec.br_off      = fe_de.instr[`BR_OFF_BITS-1:0];
        dec.jump_target = fe_de.instr[`JUMP_BITS-1:0];

        // load and load-high take the constant unsigned
        if (dec.alu_op == isa_pkg::ALU_LOAD || dec.alu_op == isa_pkg::ALU_LOADHI)
            dec.const_ext = {{(`XLEN-`CONST_BITS){1'b0}}, const_raw};
        else
            dec.const_ext = {{(`XLEN-`CONST_BITS){const_raw[`CONST_BITS-1]}}, const_raw};

        dec.reg_write = (dec.opcode == isa_pkg::OP_ALU_REG ||
                         dec.opcode == isa_pkg::OP_ALU_CONST) && dec.dreg != '0;
    end

    // r0 reads zero, a write in this same cycle goes straight through
    always_comb
    begin
        if (dec.areg == '0)
            a_val = '0;
        else if (wb_fire && wb_data.dreg == dec.areg)
            a_val = wb_data.value;
        else
            a_val = regs[dec.areg];

        if (dec.breg == '0)
            b_val = '0;
        else if (wb_fire && wb_data.dreg == dec.breg)
            b_val = wb_data.value;
        else
            b_val = regs[dec.breg];
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < `REG_COUNT; i++)
                regs[i] <= '0;
        end
        else if (wb_fire)
            regs[wb_data.dreg] <= wb_data.value;    // only on a port transfer
    end

    always_ff @(posedge clk)
    begin
        if (reset || ctrl.flush_front)
            de_ex <= '0;
        else if (!ctrl.hold_all)
        begin
            de_ex.dec   <= dec;
            de_ex.a_val <= a_val;
            de_ex.b_val <= b_val;
            de_ex.pc    <= fe_de.pc;
        end
    end

    a_no_r0_write: assert property (@(posedge clk) disable iff (reset)
        wb_fire |-> wb_data.dreg != '0);

endmodule

/* logic/execute_stage.sv */
//////////////////////////////////////////////////
// execute stage
// operand forwarding, constant select, alu,
// execute/memory latch
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "cpu_config.svh"

module execute_stage
(
    input  logic                   clk,
    input  logic                   reset,
    input  pipe_pkg::hazard_ctrl_t ctrl,
    input  pipe_pkg::de_ex_t       de_ex,
    input  logic [`XLEN-1:0]       mem_result,
    input  pipe_pkg::wb_t          wb_data,
    output pipe_pkg::ex_mem_t      ex_mem
);

    logic [`XLEN-1:0] fwd_a;
    logic [`XLEN-1:0] fwd_b;
    logic [`XLEN-1:0] alu_b;
    logic [`XLEN-1:0] result;

    always_comb
    begin
        case (ctrl.fwd_a)
            pipe_pkg::FWD_MEM: fwd_a = mem_result;
            pipe_pkg::FWD_WB:  fwd_a = wb_data.value;
            default:           fwd_a = de_ex.a_val;
        endcase

        case (ctrl.fwd_b)
            pipe_pkg::FWD_MEM: fwd_b = mem_result;
            pipe_pkg::FWD_WB:  fwd_b = wb_data.value;
            default:           fwd_b = de_ex.b_val;
        endcase
    end

    // constant overrides b after forwarding, breg bits overlap the constant
    assign alu_b = (de_ex.dec.opcode == isa_pkg::OP_ALU_CONST) ? de_ex.dec.const_ext : fwd_b;

    always_comb
    begin
        case (de_ex.dec.alu_op)
            isa_pkg::ALU_OR:     result = fwd_a | alu_b;
            isa_pkg::ALU_AND:    result = fwd_a & alu_b;
            isa_pkg::ALU_XOR:    result = fwd_a ^ alu_b;
            isa_pkg::ALU_ADD:    result = fwd_a + alu_b;
            isa_pkg::ALU_SUB:    result = fwd_a - alu_b;
            isa_pkg::ALU_SHL:    result = fwd_a << alu_b[4:0];
            isa_pkg::ALU_SHR:    result = fwd_a >> alu_b[4:0];
            isa_pkg::ALU_NOTA:   result = ~fwd_a;
            isa_pkg::ALU_LOAD:   result = alu_b;
            isa_pkg::ALU_LOADHI: result = {alu_b[15:0], fwd_a[15:0]};  // constant on top
            default:             result = '0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset || ctrl.flush_front)
            ex_mem <= '0;
        else if (!ctrl.hold_all)
        begin
            ex_mem.result <= result;
            ex_mem.a_val  <= fwd_a;     // branch compare uses these
            ex_mem.b_val  <= fwd_b;
            ex_mem.dec    <= de_ex.dec;
            ex_mem.pc     <= de_ex.pc;
        end
    end

endmodule

/* logic/fetch_unit.sv */
//////////////////////////////////////////////////
// program counter and fetch/decode latch
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "cpu_config.svh"

module fetch_unit
(
    input  logic                   clk,
    input  logic                   reset,
    input  pipe_pkg::hazard_ctrl_t ctrl,
    input  logic                   redirect,
    input  logic [`XLEN-1:0]       redirect_target,
    input  logic [`XLEN-1:0]       fetch_instr,
    output logic [`XLEN-1:0]       fetch_addr,
    output pipe_pkg::fe_de_t       fe_de
);

    logic [`XLEN-1:0] pc;

    assign fetch_addr = pc;     // instruction comes back in the same cycle

    always_ff @(posedge clk)
    begin
        if (reset)
            pc <= `PC_START;
        else if (ctrl.hold_all)
            pc <= pc;
        else if (redirect)
            pc <= redirect_target;
        else
            pc <= pc + 1'b1;    // one word per instruction
    end

    always_ff @(posedge clk)
    begin
        if (reset || ctrl.flush_front)
            fe_de <= '0;        // bubble
        else if (!ctrl.hold_all)
        begin
            fe_de.instr <= fetch_instr;
            fe_de.pc    <= pc;
        end
    end

endmodule

/* logic/hazard_control.sv */
//////////////////////////////////////////////////
// pipeline control
// flush on redirect, hold on back-pressure,
// operand forwarding selects for execute
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "cpu_config.svh"

module hazard_control
(
    input  logic                   redirect,
    input  logic                   wb_valid,
    input  logic                   wb_ready,
    input  logic [`REG_BITS-1:0]   ex_areg,
    input  logic [`REG_BITS-1:0]   ex_breg,
    input  logic [`REG_BITS-1:0]   mem_dreg,
    input  logic                   mem_dreg_we,
    input  logic [`REG_BITS-1:0]   wb_dreg,
    output pipe_pkg::hazard_ctrl_t ctrl
);

    // younger result wins, register 0 never forwards
    function automatic pipe_pkg::fwd_sel_e pick_source(input logic [`REG_BITS-1:0] src);
        pipe_pkg::fwd_sel_e sel;
        sel = pipe_pkg::FWD_NONE;
        if (src != '0)
        begin
            if (mem_dreg_we && mem_dreg == src)
                sel = pipe_pkg::FWD_MEM;
            else if (wb_valid && wb_dreg == src)   // wb_valid implies a register write
                sel = pipe_pkg::FWD_WB;
        end
        return sel;
    endfunction

    always_comb
    begin
        ctrl.hold_all    = wb_valid && !wb_ready;
        ctrl.flush_front = redirect && !ctrl.hold_all;  // redirect waits out a hold
        ctrl.fwd_a       = pick_source(ex_areg);
        ctrl.fwd_b       = pick_source(ex_breg);
    end

endmodule

/* logic/isa_pkg.sv */
//////////////////////////////////////////////////
// instruction set types
// opcodes, alu operations, branch conditions
// and the decoded instruction record
//////////////////////////////////////////////////
`include "cpu_config.svh"

package isa_pkg;

    // values not listed here decode as a no-op
    typedef enum logic [3:0] {
        OP_ALU_REG   = 4'd0,
        OP_ALU_CONST = 4'd1,
        OP_BRANCH    = 4'd2,
        OP_JUMP      = 4'd3,
        OP_HALT      = 4'd4
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_OR     = 4'd0,
        ALU_AND    = 4'd1,
        ALU_XOR    = 4'd2,
        ALU_ADD    = 4'd3,
        ALU_SUB    = 4'd4,
        ALU_SHL    = 4'd5,
        ALU_SHR    = 4'd6,
        ALU_NOTA   = 4'd7,
        ALU_LOAD   = 4'd12,
        ALU_LOADHI = 4'd13
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_EQ = 3'd0,
        BR_GT = 3'd1,
        BR_GE = 3'd2,
        BR_U1 = 3'd3,   // never taken
        BR_NE = 3'd4,
        BR_LT = 3'd5,
        BR_LE = 3'd6,
        BR_U2 = 3'd7    // never taken
    } branch_op_e;

    typedef struct packed {
        opcode_e                 opcode;
        alu_op_e                 alu_op;
        branch_op_e              branch_op;
        logic                    sig;          // signed compare
        logic [`REG_BITS-1:0]    areg;
        logic [`REG_BITS-1:0]    breg;
        logic [`REG_BITS-1:0]    dreg;
        logic [`XLEN-1:0]        const_ext;    // already extended for the alu op
        logic [`BR_OFF_BITS-1:0] br_off;
        logic [`JUMP_BITS-1:0]   jump_target;
        logic                    reg_write;    // alu op with nonzero dreg
    } decoded_t;

endpackage

/* logic/pipe_pkg.sv */
//////////////////////////////////////////////////
// pipeline types
// stage latch payloads, write-back record,
// forwarding select and hazard control bundle
//////////////////////////////////////////////////
`include "cpu_config.svh"

package pipe_pkg;

    // fetch -> decode
    typedef struct packed {
        logic [`XLEN-1:0] instr;
        logic [`XLEN-1:0] pc;
    } fe_de_t;

    // decode -> execute
    typedef struct packed {
        isa_pkg::decoded_t dec;
        logic [`XLEN-1:0]  a_val;
        logic [`XLEN-1:0]  b_val;
        logic [`XLEN-1:0]  pc;
    } de_ex_t;

    // execute -> memory, operands are the forwarded ones
    typedef struct packed {
        logic [`XLEN-1:0]  result;
        logic [`XLEN-1:0]  a_val;
        logic [`XLEN-1:0]  b_val;
        isa_pkg::decoded_t dec;
        logic [`XLEN-1:0]  pc;
    } ex_mem_t;

    typedef struct packed {
        logic [`REG_BITS-1:0] dreg;
        logic [`XLEN-1:0]     value;
    } wb_t;

    typedef enum logic [1:0] {
        FWD_NONE = 2'd0,
        FWD_MEM  = 2'd1,
        FWD_WB   = 2'd2
    } fwd_sel_e;

    typedef struct packed {
        logic     hold_all;     // write-back port back-pressured
        logic     flush_front;  // clear fe/de, de/ex and ex/mem latches
        fwd_sel_e fwd_a;
        fwd_sel_e fwd_b;
    } hazard_ctrl_t;

endpackage

/* run_sim.sh */
#!/bin/sh
# build the pipeline testbench with verilator, run it, check the log

cd "$(dirname "$0")" || exit 1

log=sim.log
bin=cpu_tb_sim

verilator --binary --timing --assert -Wno-fatal \
    --top-module cpu_tb -f b32p_lite.f -o "$bin"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/"$bin" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Everything OK" "$log"; then
    echo "result: pass"
    exit 0
fi
echo "result: fail"
exit 1

/* sim/cpu_tb.sv */
//////////////////////////////////////////////////
// pipeline testbench
// clock, reset, random programs and rom port,
// sequential isa model, write-back checks, watchdog
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpu_tb;

    localparam int CLK_PERIOD      = 100;
    localparam int ROM_WORDS       = 256;
    localparam int PROG_LEN        = 48;
    localparam int NUM_TESTS       = 5;
    localparam int RUNS_PER_TEST   = 6;
    localparam int WATCHDOG_CYCLES = NUM_TESTS * RUNS_PER_TEST * (PROG_LEN + 64) * 8;

    logic             clk;
    logic             reset;
    logic [`XLEN-1:0] fetch_addr;
    logic [`XLEN-1:0] fetch_instr;
    logic             wb_valid;
    logic             wb_ready;
    pipe_pkg::wb_t    wb_data;

    logic [`XLEN-1:0] rom [ROM_WORDS];
    pipe_pkg::wb_t    exp_q [$];        // records the model expects, in order
    int               errors;
    int               checks;
    int               records;
    int               br_count;         // cycles through conditions and signedness
    int               taken_cnt;
    int               not_taken_cnt;

    cpu_top uut (
        .clk         (clk),
        .reset       (reset),
        .fetch_addr  (fetch_addr),
        .fetch_instr (fetch_instr),
        .wb_valid    (wb_valid),
        .wb_ready    (wb_ready),
        .wb_data     (wb_data)
    );

    // unused words hold a no-op opcode mixed with their address
    function automatic logic [`XLEN-1:0] fill_word(input logic [`XLEN-1:0] addr);
        return {4'hF, addr[27:0] ^ {24'h0, addr[31:28]}};
    endfunction

    always_comb
    begin
        if (fetch_addr < ROM_WORDS)
            fetch_instr = rom[fetch_addr[7:0]];
        else
            fetch_instr = fill_word(fetch_addr);
    end

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog: run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("Something failed");
        $finish;
    end

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    function automatic logic [3:0] pick_reg(input int mode, input bit dest);
        case (mode)
            0:       return 4'($urandom_range(15, 0));
            1:       return dest ? 4'($urandom_range(3, 1)) : 4'($urandom_range(3, 0));
            4:       return ($urandom_range(99, 0) < 40) ? 4'h0 : 4'($urandom_range(7, 1));
            default: return 4'($urandom_range(7, 0));
        endcase
    endfunction

    task automatic build_program(input int mode);
        int          i;
        int          len;
        int          kind;
        int          span;
        logic [3:0]  d;
        logic [3:0]  a;
        logic [3:0]  b;
        logic [15:0] cval;
        logic [2:0]  cond;
        logic        sig;
        for (i = 0; i < ROM_WORDS; i++)
            rom[i] = fill_word(32'(i));
        len = $urandom_range(PROG_LEN, PROG_LEN / 2);
        for (i = 0; i < len - 1; i++)
        begin
            kind = (mode == 2 || mode == 3) ? $urandom_range(99, 0) : 100;
            d    = pick_reg(mode, 1'b1);
            a    = pick_reg(mode, 1'b0);
            b    = ($urandom_range(3, 0) == 0) ? a : pick_reg(mode, 1'b0);  // equal now and then
            span = (len - 1 - i < 6) ? len - 1 - i : 6;     // stays at or before the halt
            if (kind < 20)
            begin
                cond = 3'(br_count % 8);
                sig  = 1'((br_count / 8) % 2);
                br_count++;
                rom[i] = {isa_pkg::OP_BRANCH, cond, sig, d, a, b, 12'($urandom_range(span, 1))};
            end
            else if (kind < 28)
                rom[i] = {isa_pkg::OP_JUMP, 1'b0, 27'(i + $urandom_range(span, 1))};
            else
            begin
                cval = $urandom_range(1, 0) ? 16'($urandom_range(15, 0)) : 16'($urandom);
                if ($urandom_range(1, 0) == 1)
                    rom[i] = {isa_pkg::OP_ALU_CONST, 4'($urandom_range(15, 0)), d, a, cval};
                else
                    rom[i] = {isa_pkg::OP_ALU_REG, 4'($urandom_range(15, 0)), d, a, b,
                              12'($urandom)};
            end
        end
        rom[len - 1] = {isa_pkg::OP_HALT, 28'h0};
    endtask

    function automatic logic [31:0] alu_result(input logic [3:0] op, input logic [31:0] a,
                                               input logic [31:0] b);
        case (op)
            isa_pkg::ALU_OR:     return a | b;
            isa_pkg::ALU_AND:    return a & b;
            isa_pkg::ALU_XOR:    return a ^ b;
            isa_pkg::ALU_ADD:    return a + b;
            isa_pkg::ALU_SUB:    return a - b;
            isa_pkg::ALU_SHL:    return a << b[4:0];
            isa_pkg::ALU_SHR:    return a >> b[4:0];
            isa_pkg::ALU_NOTA:   return ~a;
            isa_pkg::ALU_LOAD:   return b;
            isa_pkg::ALU_LOADHI: return {b[15:0], a[15:0]};
            default:             return 32'h0;
        endcase
    endfunction

    function automatic logic cond_holds(input logic [2:0] cond, input logic sig,
                                        input logic [31:0] a, input logic [31:0] b);
        logic gt;
        logic lt;
        gt = sig ? ($signed(a) > $signed(b)) : (a > b);
        lt = sig ? ($signed(a) < $signed(b)) : (a < b);
        case (cond)
            3'd0:    return a == b;
            3'd1:    return gt;
            3'd2:    return !lt;
            3'd4:    return a != b;
            3'd5:    return lt;
            3'd6:    return !gt;
            default: return 1'b0;   // 3 and 7
        endcase
    endfunction

    // runs the program one instruction at a time
    task automatic run_model(output logic [31:0] halt_addr);
        logic [31:0]   regs [16];
        logic [31:0]   pc;
        logic [31:0]   instr;
        logic [31:0]   a;
        logic [31:0]   b;
        logic [3:0]    op;
        logic [3:0]    d;
        pipe_pkg::wb_t rec;
        int            step;
        for (step = 0; step < 16; step++)
            regs[step] = '0;
        exp_q.delete();
        pc        = `PC_START;
        halt_addr = '1;
        for (step = 0; step < 4 * ROM_WORDS && halt_addr == '1; step++)
        begin
            instr = (pc < ROM_WORDS) ? rom[pc[7:0]] : fill_word(pc);
            op    = instr[27:24];
            d     = instr[23:20];
            a     = regs[instr[19:16]];
            b     = regs[instr[15:12]];
            case (instr[31:28])
                isa_pkg::OP_ALU_REG, isa_pkg::OP_ALU_CONST:
                begin
                    if (instr[31:28] == isa_pkg::OP_ALU_CONST)
                    begin
                        if (op == isa_pkg::ALU_LOAD || op == isa_pkg::ALU_LOADHI)
                            b = {16'h0, instr[15:0]};
                        else
                            b = {{16{instr[15]}}, instr[15:0]};
                    end
                    if (d != 4'h0)
                    begin
                        regs[d]   = alu_result(op, a, b);
                        rec.dreg  = d;
                        rec.value = regs[d];
                        exp_q.push_back(rec);
                    end
                    pc = pc + 1;
                end
                isa_pkg::OP_BRANCH:
                begin
                    if (cond_holds(instr[27:25], instr[24], a, b))
                    begin
                        pc = pc + {{20{instr[11]}}, instr[11:0]};
                        taken_cnt++;
                    end
                    else
                    begin
                        pc = pc + 1;
                        not_taken_cnt++;
                    end
                end
                isa_pkg::OP_JUMP: pc = {5'h0, instr[26:0]};
                isa_pkg::OP_HALT: halt_addr = pc;
                default:          pc = pc + 1;
            endcase
        end
    endtask

    task automatic run_program(input int mode, input int ready_pct);
        logic [31:0]   halt_addr;
        pipe_pkg::wb_t held;
        logic          waiting;
        logic          seen_halt;
        int            idx;
        int            cyc;
        int            in_range;
        @(posedge clk);
        #5;
        reset    = 1'b1;
        wb_ready = 1'b0;
        build_program(mode);
        run_model(halt_addr);
        repeat (16) @(posedge clk);
        #5;
        reset = 1'b0;
        check_value("fetch_addr", 64'(fetch_addr), 64'(`PC_START));
        check_value("wb_valid", 64'(wb_valid), 64'(0));

        idx     = 0;
        waiting = 1'b0;
        held    = '0;
        while (idx < exp_q.size())
        begin
            if (wb_valid && wb_data.dreg == 4'h0)
            begin
                errors++;
                $display("write-back valid raised for register 0 at %0t", $time);
            end
            if (waiting)    // record left waiting last cycle
            begin
                check_value("wb_valid", 64'(wb_valid), 64'(1));
                check_value("wb_data", {28'h0, wb_data}, {28'h0, held});
            end
            wb_ready = ($urandom_range(99, 0) < ready_pct);
            if (wb_valid && wb_ready)
            begin
                check_value("wb_data.dreg", 64'(wb_data.dreg), 64'(exp_q[idx].dreg));
                check_value("wb_data.value", 64'(wb_data.value), 64'(exp_q[idx].value));
                idx++;
            end
            waiting = wb_valid && !wb_ready;
            held    = wb_data;
            @(posedge clk);
            #5;
        end
        records += exp_q.size();

        // halt loop walks halt_addr .. halt_addr+3
        wb_ready  = 1'b1;
        in_range  = 0;
        seen_halt = 1'b0;
        for (cyc = 0; cyc < 4 * PROG_LEN + 32 && in_range < 8; cyc++)
        begin
            check_value("wb_valid", 64'(wb_valid), 64'(0));
            if (fetch_addr >= halt_addr && fetch_addr <= halt_addr + 3)
            begin
                in_range++;
                seen_halt = seen_halt || (fetch_addr == halt_addr);
            end
            else
            begin
                in_range  = 0;
                seen_halt = 1'b0;
            end
            @(posedge clk);
            #5;
        end
        if (in_range < 8 || !seen_halt)
        begin
            errors++;
            $display("fetch address did not settle on the halt address 0x%0h", halt_addr);
        end
    endtask

    task automatic run_test(input int num, input string name, input int mode,
                            input int ready_pct);
        int err_start;
        int rec_start;
        err_start     = errors;
        rec_start     = records;
        taken_cnt     = 0;
        not_taken_cnt = 0;
        repeat (RUNS_PER_TEST) run_program(mode, ready_pct);
        $display("test %0d %s: %0d programs, %0d records, branches %0d taken %0d not, %0d errors",
                 num, name, RUNS_PER_TEST, records - rec_start, taken_cnt, not_taken_cnt,
                 errors - err_start);
    endtask

    initial
    begin
        int i;
        reset    = 1'b1;
        wb_ready = 1'b0;
        errors   = 0;
        checks   = 0;
        records  = 0;
        br_count = 0;
        for (i = 0; i < ROM_WORDS; i++)
            rom[i] = fill_word(32'(i));
        void'($urandom(4));

        run_test(1, "alu results", 0, 100);
        run_test(2, "forwarding", 1, 100);
        run_test(3, "branches and jumps", 2, 100);
        run_test(4, "back-pressure", 3, 50);
        run_test(5, "halt and register 0", 4, 100);

        $display("%0d tests, %0d checks, %0d records, %0d errors",
                 NUM_TESTS, checks, records, errors);
        if (errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule
